/* verilog/load_pkg.sv */
package load_pkg;

  // station index width, 2**rs_idx_w entries
  localparam int rs_idx_w = 3;

  // number of station entries
  localparam int rs_entries = 2 ** rs_idx_w;

  // width of a reorder buffer tag
  localparam int rob_idx_w = 3;

  // common data bus ports snooped for wakeup
  localparam int cdb_ports = 3;

  // load kinds, funct3 field of the RV32I load opcode
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

endpackage

/* verilog/load_align.sv */
module load_align (
  input  load_pkg::load_funct3_t funct3,
  input  logic [1:0]             offset,
  input  logic [31:0]            rdata,
  output logic [31:0]            value
);

  import load_pkg::*;

  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  // byte lane by full offset, half lane by its upper bit
  assign byte_lane = rdata[8*offset +: 8];
  assign half_lane = offset[1] ? rdata[31:16] : rdata[15:0];

  always_comb begin
    case (funct3)
      lb: begin
        value = {{24{byte_lane[7]}}, byte_lane};
      end
      lbu: begin
        value = {24'b0, byte_lane};
      end
      lh: begin
        value = {{16{half_lane[15]}}, half_lane};
      end
      lhu: begin
        value = {16'b0, half_lane};
      end
      default: begin
        // lw takes the whole word
        value = rdata;
      end
    endcase
  end

endmodule

/* verilog/load_rs.sv */
module load_rs (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush,

  // issue side
  input  logic                           issue,
  input  load_pkg::load_funct3_t         issue_funct3,
  input  logic [31:0]                    issue_imm,
  input  logic [load_pkg::rob_idx_w-1:0] issue_rob,
  input  logic                           rf_ready,
  input  logic [31:0]                    rf_value,
  input  logic [load_pkg::rob_idx_w-1:0] rf_rob,
  input  logic                           rob_ready,
  input  logic [31:0]                    rob_value,
  output logic                           full,

  // broadcast snoop
  input  logic                           cdb_valid [load_pkg::cdb_ports],
  input  logic [load_pkg::rob_idx_w-1:0] cdb_rob   [load_pkg::cdb_ports],
  input  logic [31:0]                    cdb_value [load_pkg::cdb_ports],

  // executor handshake
  input  logic                           busy,
  input  logic                           done,
  output logic                           grant,
  output logic [load_pkg::rob_idx_w-1:0] grant_rob,
  output logic [31:0]                    grant_base,
  output logic [31:0]                    grant_imm,
  output load_pkg::load_funct3_t         grant_funct3
);

  import load_pkg::*;

  // entry state
  logic [rs_entries-1:0] valid;
  logic [rs_entries-1:0] ready;

  // entry payload
  logic [31:0]          base     [rs_entries];
  logic [31:0]          imm      [rs_entries];
  logic [rob_idx_w-1:0] wait_rob [rs_entries];
  logic [rob_idx_w-1:0] dest_rob [rs_entries];
  load_funct3_t         funct3   [rs_entries];

  logic [rs_idx_w-1:0] free_idx;
  logic [rs_idx_w-1:0] ptr;
  logic [rs_idx_w-1:0] sel_idx;
  logic                sel_found;
  logic [rs_idx_w-1:0] gnt_idx;
  logic                accept;

  logic [rs_entries-1:0] wake;
  logic [31:0]           wake_val [rs_entries];

  assign full   = &valid;
  assign accept = issue && !full;

  // lowest free slot takes the next issue
  always_comb begin
    free_idx = '0;
    for (int i = rs_entries - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_idx = rs_idx_w'(i);
      end
    end
  end

  // tag match against every broadcast port
  always_comb begin
    for (int i = 0; i < rs_entries; i++) begin
      wake[i]     = 1'b0;
      wake_val[i] = '0;
      for (int j = 0; j < cdb_ports; j++) begin
        if (valid[i] && !ready[i] && cdb_valid[j] && cdb_rob[j] == wait_rob[i]) begin
          wake[i]     = 1'b1;
          wake_val[i] = cdb_value[j];
        end
      end
    end
  end

  // round robin search starting at ptr
  always_comb begin
    logic [rs_idx_w-1:0] cand;
    sel_found = 1'b0;
    sel_idx   = '0;
    cand      = '0;
    for (int k = 0; k < rs_entries; k++) begin
      cand = rs_idx_w'(ptr + k);
      if (!sel_found && valid[cand] && ready[cand]) begin
        sel_found = 1'b1;
        sel_idx   = cand;
      end
    end
  end

  // one load at a time, only while the executor is idle
  assign grant        = sel_found && !busy;
  assign grant_rob    = dest_rob[sel_idx];
  assign grant_base   = base[sel_idx];
  assign grant_imm    = imm[sel_idx];
  assign grant_funct3 = funct3[sel_idx];

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      valid   <= '0;
      ready   <= '0;
      ptr     <= '0;
      gnt_idx <= '0;
    end else begin
      if (accept) begin
        valid[free_idx] <= 1'b1;
        ready[free_idx] <= rf_ready || rob_ready;
      end
      for (int i = 0; i < rs_entries; i++) begin
        if (wake[i]) begin
          ready[i] <= 1'b1;
        end
      end
      if (grant) begin
        gnt_idx <= sel_idx;
      end
      // release on the response and move the pointer past it
      if (done) begin
        valid[gnt_idx] <= 1'b0;
        ptr            <= rs_idx_w'(gnt_idx + 1'b1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      imm[free_idx]      <= issue_imm;
      funct3[free_idx]   <= issue_funct3;
      dest_rob[free_idx] <= issue_rob;
      wait_rob[free_idx] <= rf_rob;
      // register file wins over the ROB copy
      base[free_idx]     <= rf_ready ? rf_value : rob_value;
    end
    for (int i = 0; i < rs_entries; i++) begin
      if (wake[i]) begin
        base[i] <= wake_val[i];
      end
    end
  end

endmodule

/* verilog/load_exec.sv */
module load_exec (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush,

  // from the station
  input  logic                           grant,
  input  logic [load_pkg::rob_idx_w-1:0] grant_rob,
  input  logic [31:0]                    grant_base,
  input  logic [31:0]                    grant_imm,
  input  load_pkg::load_funct3_t         grant_funct3,
  output logic                           busy,
  output logic                           done,

  // memory
  output logic [31:0]                    dmem_addr,
  output logic [3:0]                     dmem_rmask,
  input  logic [31:0]                    dmem_rdata,
  input  logic                           dmem_resp,

  // result broadcast
  output logic                           res_valid,
  output logic [load_pkg::rob_idx_w-1:0] res_rob,
  output logic [31:0]                    res_value
);

  import load_pkg::*;

  logic                 start;
  logic [rob_idx_w-1:0] rob_q;
  logic [31:0]          base_q;
  logic [31:0]          imm_q;
  load_funct3_t         funct3_q;
  logic [31:0]          eff_addr;
  logic [3:0]           mask;

  assign eff_addr  = base_q + imm_q;
  assign dmem_addr = {eff_addr[31:2], 2'b00};

  always_comb begin
    case (funct3_q)
      lb, lbu: mask = 4'b0001 << eff_addr[1:0];
      lh, lhu: mask = 4'b0011 << eff_addr[1:0];
      lw:      mask = 4'b1111;
      default: mask = 4'b0000;
    endcase
  end

  // request lasts only the first busy cycle, killed by flush
  assign dmem_rmask = (start && !flush) ? mask : 4'b0000;

  assign done      = busy && dmem_resp && !flush;
  assign res_valid = done;
  assign res_rob   = rob_q;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      busy  <= 1'b0;
      start <= 1'b0;
    end else begin
      start <= grant;
      if (grant) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      rob_q    <= grant_rob;
      base_q   <= grant_base;
      imm_q    <= grant_imm;
      funct3_q <= grant_funct3;
    end
  end

  load_align u_align (
    .funct3 (funct3_q),
    .offset (eff_addr[1:0]),
    .rdata  (dmem_rdata),
    .value  (res_value)
  );

endmodule

/* verilog/load_unit_top.sv */
module load_unit_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush,

  // issue
  input  logic                           issue,
  input  load_pkg::load_funct3_t         issue_funct3,
  input  logic [31:0]                    issue_imm,
  input  logic [load_pkg::rob_idx_w-1:0] issue_rob,
  input  logic                           rf_ready,
  input  logic [31:0]                    rf_value,
  input  logic [load_pkg::rob_idx_w-1:0] rf_rob,
  input  logic                           rob_ready,
  input  logic [31:0]                    rob_value,
  output logic                           full,

  // broadcast snoop
  input  logic                           cdb_valid [load_pkg::cdb_ports],
  input  logic [load_pkg::rob_idx_w-1:0] cdb_rob   [load_pkg::cdb_ports],
  input  logic [31:0]                    cdb_value [load_pkg::cdb_ports],

  // memory
  output logic [31:0]                    dmem_addr,
  output logic [3:0]                     dmem_rmask,
  input  logic [31:0]                    dmem_rdata,
  input  logic                           dmem_resp,

  // result
  output logic                           res_valid,
  output logic [load_pkg::rob_idx_w-1:0] res_rob,
  output logic [31:0]                    res_value
);

  import load_pkg::*;

  // station to executor
  logic                 grant;
  logic [rob_idx_w-1:0] grant_rob;
  logic [31:0]          grant_base;
  logic [31:0]          grant_imm;
  load_funct3_t         grant_funct3;
  logic                 busy;
  logic                 done;

  load_rs u_rs (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .issue        (issue),
    .issue_funct3 (issue_funct3),
    .issue_imm    (issue_imm),
    .issue_rob    (issue_rob),
    .rf_ready     (rf_ready),
    .rf_value     (rf_value),
    .rf_rob       (rf_rob),
    .rob_ready    (rob_ready),
    .rob_value    (rob_value),
    .full         (full),
    .cdb_valid    (cdb_valid),
    .cdb_rob      (cdb_rob),
    .cdb_value    (cdb_value),
    .busy         (busy),
    .done         (done),
    .grant        (grant),
    .grant_rob    (grant_rob),
    .grant_base   (grant_base),
    .grant_imm    (grant_imm),
    .grant_funct3 (grant_funct3)
  );

  load_exec u_exec (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .grant        (grant),
    .grant_rob    (grant_rob),
    .grant_base   (grant_base),
    .grant_imm    (grant_imm),
    .grant_funct3 (grant_funct3),
    .busy         (busy),
    .done         (done),
    .dmem_addr    (dmem_addr),
    .dmem_rmask   (dmem_rmask),
    .dmem_rdata   (dmem_rdata),
    .dmem_resp    (dmem_resp),
    .res_valid    (res_valid),
    .res_rob      (res_rob),
    .res_value    (res_value)
  );

endmodule

/* tests/dmem_model.sv */
module dmem_model #(
  parameter logic [31:0] fill_key = 32'h5a5a_c3c3
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        stall,
  input  logic        cancel,
  input  logic [31:0] addr,
  input  logic [3:0]  rmask,
  output logic        resp,
  output logic [31:0] rdata
);

  logic        pending;
  logic        hold;
  logic [31:0] addr_q;
  int          delay;

  // one request at a time, answered 1 to 4 cycles later
  initial begin
    resp    = 1'b0;
    rdata   = '0;
    pending = 1'b0;
    hold    = 1'b0;
    addr_q  = '0;
    delay   = 0;
    forever begin
      @(posedge clk);
      hold = stall;
      if (!rst_n || cancel) begin
        pending = 1'b0;
      end else if (rmask != 4'b0000) begin
        pending = 1'b1;
        addr_q  = addr;
        delay   = $urandom_range(0, 3);
      end else if (resp) begin
        pending = 1'b0;
      end else if (pending && delay > 0) begin
        delay = delay - 1;
      end
      #1;
      resp  = pending && delay == 0 && !hold;
      // word data depends on the whole aligned address
      rdata = addr_q ^ fill_key;
    end
  end

endmodule

/* tests/tb_load_unit.sv */
module tb_load_unit;

  import load_pkg::*;

  localparam int n_tags = 2 ** rob_idx_w;
  localparam int n_loads = 64;
  localparam logic [31:0] fill_key = 32'h5a5a_c3c3;

  logic clk, rst_n, flush, issue, rf_ready, rob_ready, full, stall;
  load_funct3_t issue_funct3;
  logic [31:0] issue_imm, rf_value, rob_value, dmem_addr, dmem_rdata, res_value;
  logic [rob_idx_w-1:0] issue_rob, rf_rob, res_rob;
  logic cdb_valid [cdb_ports];
  logic [rob_idx_w-1:0] cdb_rob [cdb_ports];
  logic [31:0] cdb_value [cdb_ports];
  logic [3:0] dmem_rmask;
  logic dmem_resp, res_valid;

  // scoreboard per ROB tag
  logic expected [n_tags];
  logic requested [n_tags];
  logic [31:0] exp_addr [n_tags];
  logic [3:0] exp_mask [n_tags];
  logic [31:0] exp_value [n_tags];
  logic waiting [n_tags];
  load_funct3_t wait_kind [n_tags];
  logic [31:0] wait_imm [n_tags];
  logic [1:0] wait_off [n_tags];
  load_funct3_t kinds [5] = '{lb, lh, lw, lbu, lhu};
  int errors = 0;
  int outstanding = 0;
  int results = 0;
  bit sweep = 1'b0;
  int sweep_idx = 0;
  int next_port = 0;
  string test_name = "reset";

  load_unit_top u_dut (.*);

  dmem_model #(.fill_key(fill_key)) u_mem (
    .clk(clk), .rst_n(rst_n), .stall(stall), .cancel(flush),
    .addr(dmem_addr), .rmask(dmem_rmask), .resp(dmem_resp), .rdata(dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(n_loads * 200 * 8);
    $display("watchdog expired in %s with %0d loads unanswered", test_name, outstanding);
    $display("TB FAILED");
    $finish;
  end

  task automatic flag_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("%s: %s", test_name, what);
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] extract_value(load_funct3_t kind, logic [1:0] off,
                                                logic [31:0] data);
    logic [31:0] sh;
    sh = data >> (8 * off);
    case (kind)
      lb:      return {{24{sh[7]}}, sh[7:0]};
      lbu:     return {24'b0, sh[7:0]};
      lh:      return {{16{sh[15]}}, sh[15:0]};
      lhu:     return {16'b0, sh[15:0]};
      default: return data;
    endcase
  endfunction

  // moves the base so that base plus imm lands on offset off
  function automatic logic [31:0] legal_base(logic [31:0] b, logic [31:0] imm, logic [1:0] off);
    return b - ((b + imm) & 32'h3) + {30'b0, off};
  endfunction

  task automatic set_expect(input logic [2:0] tag, input load_funct3_t kind, input logic [31:0] a);
    int nbytes;
    exp_addr[tag] = {a[31:2], 2'b00};
    case (kind)
      lb, lbu: nbytes = 1;
      lh, lhu: nbytes = 2;
      default: nbytes = 4;
    endcase
    // one mask bit per byte the load touches
    for (int i = 0; i < 4; i++) begin
      exp_mask[tag][i] = (i >= int'(a[1:0])) && (i < int'(a[1:0]) + nbytes);
    end
    exp_value[tag] = extract_value(kind, a[1:0], exp_addr[tag] ^ fill_key);
    expected[tag] = 1'b1;
    outstanding++;
  endtask

  // src 0 register file, 1 ROB copy, 2 waits on the CDB for its own tag
  task automatic issue_load(input logic [2:0] tag, input int src, input bit track);
    load_funct3_t kind;
    logic [31:0] imm, base, r;
    logic [1:0] off;
    // the sweep walks every kind through every byte offset
    if (sweep) begin
      kind = kinds[(sweep_idx / 4) % 5];
      off = 2'(sweep_idx % 4);
      sweep_idx++;
    end else begin
      kind = kinds[$urandom_range(0, 4)];
      off = 2'($urandom_range(0, 3));
    end
    // halves on even offsets, words aligned
    case (kind)
      lh, lhu: off[0] = 1'b0;
      lw:      off = 2'b00;
      default: ;
    endcase
    r = $urandom;
    imm = {{20{r[11]}}, r[11:0]};
    base = legal_base($urandom, imm, off);
    issue = 1'b1;
    issue_funct3 = kind;
    issue_imm = imm;
    issue_rob = tag;
    rf_rob = tag;
    rf_ready = (src == 0);
    rob_ready = (src == 1) || (src == 0 && $urandom_range(0, 1) == 1);
    rf_value = (src == 0) ? base : base + 32'h200;
    rob_value = (src == 1) ? base : base + 32'h100;
    if (src == 2) begin
      waiting[tag] = 1'b1;
      wait_kind[tag] = kind;
      wait_imm[tag] = imm;
      wait_off[tag] = off;
    end else if (track) begin
      set_expect(tag, kind, base + imm);
    end
    tick();
    issue = 1'b0;
    rf_ready = 1'b0;
    rob_ready = 1'b0;
  endtask

  task automatic wake_waiting();
    int port;
    logic [31:0] v;
    for (int t = 0; t < n_tags; t++) begin
      if (waiting[t]) begin
        repeat ($urandom_range(2, 5)) tick();
        // ports taken in turn
        port = next_port;
        next_port = (next_port + 1) % cdb_ports;
        v = legal_base($urandom, wait_imm[t], wait_off[t]);
        set_expect(3'(t), wait_kind[t], v + wait_imm[t]);
        cdb_valid[port] = 1'b1;
        cdb_rob[port] = 3'(t);
        cdb_value[port] = v;
        waiting[t] = 1'b0;
        tick();
        cdb_valid[port] = 1'b0;
      end
    end
  endtask

  task automatic drain();
    while (outstanding != 0) begin
      tick();
    end
  endtask

  // request and result monitor, sampled at the rising edge
  always @(posedge clk) begin
    if (rst_n) begin
      if (flush) begin
        assert (dmem_rmask == 4'b0000) else flag_mismatch("flush mask", 0, 32'(dmem_rmask));
      end
      if (dmem_rmask != 4'b0000) begin
        assert (expected[res_rob] && !requested[res_rob])
          else report_problem("request for a tag that is not pending");
        assert (dmem_addr == exp_addr[res_rob])
          else flag_mismatch("addr", exp_addr[res_rob], dmem_addr);
        assert (dmem_rmask == exp_mask[res_rob])
          else flag_mismatch("mask", 32'(exp_mask[res_rob]), 32'(dmem_rmask));
        requested[res_rob] = 1'b1;
      end
      if (res_valid) begin
        assert (expected[res_rob] && requested[res_rob])
          else report_problem("result for a tag with no open request");
        if (expected[res_rob]) begin
          assert (res_value == exp_value[res_rob])
            else flag_mismatch("value", exp_value[res_rob], res_value);
          expected[res_rob] = 1'b0;
          outstanding--;
        end
        requested[res_rob] = 1'b0;
        results++;
      end
    end
  end

  initial begin
    int r0;
    void'($urandom(32'h6a0d5207));
    {rst_n, flush, issue, rf_ready, rob_ready, stall} = '0;
    issue_funct3 = lw;
    {issue_imm, rf_value, rob_value, issue_rob, rf_rob} = '0;
    for (int p = 0; p < cdb_ports; p++) begin
      cdb_valid[p] = 1'b0;
      cdb_rob[p] = '0;
      cdb_value[p] = '0;
    end
    for (int t = 0; t < n_tags; t++) begin
      {expected[t], requested[t], waiting[t]} = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert (!full && dmem_rmask == 4'b0000 && !res_valid)
      else report_problem("outputs not idle after reset");

    test_name = "ready_loads";
    sweep = 1'b1;
    repeat (3) begin
      for (int t = 0; t < n_tags; t++) issue_load(3'(t), $urandom_range(0, 1), 1);
      drain();
    end
    sweep = 1'b0;

    // tags 2 and 5 wait on the CDB
    test_name = "cdb_wakeup";
    repeat (2) begin
      for (int t = 0; t < n_tags; t++) issue_load(3'(t), t % 3, 1);
      wake_waiting();
      drain();
    end

    test_name = "capacity";
    stall = 1'b1;
    for (int t = 0; t < n_tags; t++) issue_load(3'(t), 0, 1);
    assert (full) else report_problem("station not full after eight issues");
    stall = 1'b0;
    r0 = results;
    while (results == r0) tick();
    assert (!full) else report_problem("full stayed high after a response");
    drain();

    test_name = "flush";
    for (int t = 0; t < n_tags - 1; t++) issue_load(3'(t), 2, 0);
    issue_load(3'(n_tags - 1), 0, 0);
    assert (full) else report_problem("station not full before flush");
    tick();
    flush = 1'b1;
    tick();
    flush = 1'b0;
    assert (!full) else report_problem("full stayed high after flush");
    for (int t = 0; t < n_tags; t++) waiting[t] = 1'b0;
    repeat (10) tick();
    for (int t = 0; t < n_tags; t++) issue_load(3'(t), $urandom_range(0, 1), 1);
    drain();
    repeat (4) tick();

    $display("check errors: %0d, unanswered loads: %0d", errors, outstanding);
    if (errors == 0 && outstanding == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
verilog/load_pkg.sv
verilog/load_align.sv
verilog/load_rs.sv
verilog/load_exec.sv
verilog/load_unit_top.sv
tests/dmem_model.sv
tests/tb_load_unit.sv

/* Makefile */
sim_bin := obj_dir/Vtb_load_unit

$(sim_bin): tb.f $(wildcard verilog/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_load_unit -f tb.f

run: $(sim_bin)
	./$(sim_bin) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
